// File: sources.f
+incdir+include
verilog/core_pkg.sv
verilog/pipeBus.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/registerFile.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/writebackStage.sv
verilog/riscvCore.sv
dv/tbChecker.sv
dv/tbTop.sv

// File: run.sh
#!/bin/sh
# Compile and run the RV32I pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module tbTop -o tbSim
./obj_dir/tbSim > sim.log 2>&1
cat sim.log
if grep -qx "Test passed" sim.log; then
	exit 0
fi
exit 1

// File: dv/tbTop.sv
// Testbench top with clock, reset, random program, memories, stall stimulus and timeout
`timescale 1ns/1ns
`include "core_settings.svh"

module tbTop;
	logic             clk = 1'b0;
	logic             rst_n = 1'b0;
	logic             memStall = 1'b0;
	logic [`XLEN-1:0] instAddr;
	logic [`XLEN-1:0] instData;
	logic             dataRead;
	logic             dataWrite;
	logic [`XLEN-1:0] dataAddr;
	logic [`XLEN-1:0] dataWdata;
	logic [`XLEN-1:0] dataRdata;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] dataInit [64];
	logic [31:0] rngState = 32'hd07;
	logic [31:0] stallRnd;
	logic        progReady = 1'b0;
	logic        endReached;
	logic        timedOut;
	int          errorCount;
	int          storeCount;
	int          expectedStores;
	int          totalErrors;
	int          cyc;

	// Index order matches the nine ALU operations
	localparam logic [3:0] aluCodes [9] = '{`ALU_ADD, `ALU_SUB, `ALU_SLL, `ALU_SLT,
		`ALU_XOR, `ALU_SRL, `ALU_SRA, `ALU_OR, `ALU_AND};

	always #10 clk = ~clk;  // 20 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// ====================================================================
	// Instruction encoders, registers limited to x0..x7
	// ====================================================================
	function automatic logic [31:0] encR(input logic [3:0] code, input logic [2:0] rd,
			input logic [2:0] rs1, input logic [2:0] rs2);
		core_pkg::instrWord w;
		w = '0;
		w.rType.opcode = `OP_RTYPE;
		w.rType.rd     = {2'b00, rd};
		w.rType.funct3 = code[2:0];
		w.rType.rs1    = {2'b00, rs1};
		w.rType.rs2    = {2'b00, rs2};
		w.rType.funct7 = {1'b0, code[3], 5'b00000};  // sub and sra flag
		return w;
	endfunction

	function automatic logic [31:0] encI(input logic [6:0] opcode, input logic [2:0] funct3,
			input logic [2:0] rd, input logic [2:0] rs1, input logic [31:0] imm);
		core_pkg::instrWord w;
		w = '0;
		w.iType.opcode = opcode;
		w.iType.rd     = {2'b00, rd};
		w.iType.funct3 = funct3;
		w.iType.rs1    = {2'b00, rs1};
		w.iType.imm    = imm[11:0];
		return w;
	endfunction

	function automatic logic [31:0] encS(input logic [2:0] rs2, input logic [31:0] imm);
		core_pkg::instrWord w;
		w = '0;
		w.sType.opcode = `OP_STORE;
		w.sType.funct3 = 3'b010;
		w.sType.rs2    = {2'b00, rs2};  // Base stays x0
		w.sType.immHi  = imm[11:5];
		w.sType.immLo  = imm[4:0];
		return w;
	endfunction

	function automatic logic [31:0] encB(input logic [2:0] funct3, input logic [2:0] rs1,
			input logic [2:0] rs2, input logic [31:0] off);
		core_pkg::instrWord w;
		w = '0;
		w.bType.opcode   = `OP_BRANCH;
		w.bType.funct3   = funct3;
		w.bType.rs1      = {2'b00, rs1};
		w.bType.rs2      = {2'b00, rs2};
		w.bType.immSign  = off[12];
		w.bType.immBit11 = off[11];
		w.bType.immHi    = off[10:5];
		w.bType.immLo    = off[4:1];
		return w;
	endfunction

	function automatic logic [31:0] encJ(input logic [2:0] rd, input logic [31:0] off);
		core_pkg::instrWord w;
		w = '0;
		w.jType.opcode   = `OP_JAL;
		w.jType.rd       = {2'b00, rd};
		w.jType.immSign  = off[20];
		w.jType.immHi    = off[19:12];
		w.jType.immBit11 = off[11];
		w.jType.immLo    = off[10:1];
		return w;
	endfunction

	task automatic buildProgram();
		logic [31:0] f;
		logic [31:0] imm;
		logic [31:0] jump;
		logic [3:0]  code;
		int          sel;
		int          span;
		int          i;
		for (i = 0; i < 64; i++)
			dataInit[i] = (i * 4) * 32'h9e37_79b1 ^ 32'h1357_9bdf;  // Hash of byte address
		for (i = 0; i < 63; i++) begin
			f    = nextRandom();
			sel  = nextRandom() % 16;
			span = (63 - i) < 8 ? 63 - i : 8;
			jump = (1 + f[31:29] % span) * 4;  // Forward, lands inside the program
			code = aluCodes[f[12:9] % 9];
			case (sel)
				0, 1, 2, 3, 4: imem[i] = encR(code, f[2:0], f[5:3], f[8:6]);
				5, 6, 7, 8: begin
					if (code == `ALU_SUB)
						code = `ALU_ADD;  // No subi
					if (code[1:0] == 2'b01)
						imm = {20'd0, 1'b0, code[3], 5'd0, f[24:20]};  // Shift amount
					else
						imm = {20'd0, f[31:20]};
					imem[i] = encI(`OP_ITYPE, code[2:0], f[2:0], f[5:3], imm);
				end
				9, 10: imem[i] = encI(`OP_LOAD, 3'b010, f[2:0], 3'b000, {24'd0, f[17:12], 2'b00});
				11, 12: imem[i] = encS(f[8:6], {24'd0, f[17:12], 2'b00});
				13, 14: imem[i] = encB(sel == 13 ? 3'b000 : 3'b001, f[5:3], f[8:6], jump);
				default: imem[i] = encJ(f[2:0], jump);
			endcase
		end
		imem[63] = encJ(3'b000, 32'd0);  // Self-loop marks the end
	endtask

	// Word-wide memories answering in the same cycle
	assign instData  = imem[instAddr[7:2]];
	assign dataRdata = dmem[dataAddr[7:2]];

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int j = 0; j < 64; j++)
				dmem[j] <= dataInit[j];
		end else if (dataWrite && !memStall) begin
			dmem[dataAddr[7:2]] <= dataWdata;
		end
	end

	always @(posedge clk) begin
		stallRnd = nextRandom();
		memStall <= rst_n && stallRnd[1:0] == 2'b00;  // About one cycle in four
	end

	riscvCore i_dut (.*);

	tbChecker uChecker (
		.clk, .rst_n, .memStall, .instAddr, .dataRead, .dataWrite, .dataAddr, .dataWdata,
		.progReady, .progMem(imem), .dataInit, .endReached, .errorCount, .storeCount,
		.expectedStores
	);

	// ====================================================================
	// Reset, run to the self-loop, final report
	// ====================================================================
	initial begin
		buildProgram();
		progReady = 1'b1;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		for (cyc = 0; cyc < 4000 && !endReached; cyc++)
			@(posedge clk);
		timedOut = !endReached;
		if (timedOut)
			$display("the program did not reach its end within 4000 cycles");
		totalErrors = errorCount + (timedOut ? 1 : 0);
		$display("stores %0d of %0d, errors %0d", storeCount, expectedStores, totalErrors);
		if (totalErrors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: dv/tbChecker.sv
// Checker with an RV32I reference model, reset checks, load and store stream comparison
`timescale 1ns/1ns
`include "core_settings.svh"

module tbChecker (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             memStall,
	input  logic [`XLEN-1:0] instAddr,
	input  logic             dataRead,
	input  logic             dataWrite,
	input  logic [`XLEN-1:0] dataAddr,
	input  logic [`XLEN-1:0] dataWdata,
	input  logic             progReady,
	input  logic [31:0]      progMem [64],
	input  logic [31:0]      dataInit [64],
	output logic             endReached,
	output int               errorCount,
	output int               storeCount,
	output int               expectedStores
);
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] expLoadAddr [$];
	logic [31:0] finalPc;
	logic        modelDone;
	logic        inReset;
	logic        reachedEnd;
	int          drainCount;
	int          loadCount;
	int          n;

	function automatic logic [31:0] aluModel(input logic [2:0] funct3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (funct3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	// ====================================================================
	// Instruction-set model stepping one instruction at a time
	// ====================================================================
	task automatic runModel();
		core_pkg::instrWord w;
		logic [31:0] regs [32];
		logic [31:0] mem [64];
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] addr;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic        alt;
		int          i;
		for (i = 0; i < 32; i++)
			regs[i] = '0;
		for (i = 0; i < 64; i++)
			mem[i] = dataInit[i];
		pc        = `RESET_PC;
		modelDone = 1'b0;
		for (i = 0; i < 256 && !modelDone; i++) begin
			w      = progMem[pc[7:2]];
			nextPc = pc + 32'd4;
			immI   = {{20{w.iType.imm[11]}}, w.iType.imm};
			immS   = {{20{w.sType.immHi[6]}}, w.sType.immHi, w.sType.immLo};
			immB   = {{19{w.bType.immSign}}, w.bType.immSign, w.bType.immBit11,
				w.bType.immHi, w.bType.immLo, 1'b0};
			immJ   = {{11{w.jType.immSign}}, w.jType.immSign, w.jType.immHi,
				w.jType.immBit11, w.jType.immLo, 1'b0};
			case (w.rType.opcode)
				`OP_RTYPE: regs[w.rType.rd] = aluModel(w.rType.funct3, w.rType.funct7[5],
					regs[w.rType.rs1], regs[w.rType.rs2]);
				`OP_ITYPE: begin
					alt = w.iType.funct3 == 3'b101 && w.iType.imm[10];  // srai
					regs[w.iType.rd] = aluModel(w.iType.funct3, alt, regs[w.iType.rs1], immI);
				end
				`OP_LOAD: begin
					addr = regs[w.iType.rs1] + immI;
					regs[w.iType.rd] = mem[addr[7:2]];
					expLoadAddr.push_back(addr);
				end
				`OP_STORE: begin
					addr = regs[w.sType.rs1] + immS;
					mem[addr[7:2]] = regs[w.sType.rs2];
					expAddr.push_back(addr);
					expData.push_back(regs[w.sType.rs2]);
				end
				`OP_BRANCH: begin
					if (w.bType.funct3[0] ? regs[w.bType.rs1] != regs[w.bType.rs2]
							: regs[w.bType.rs1] == regs[w.bType.rs2])
						nextPc = pc + immB;
				end
				`OP_JAL: begin
					regs[w.jType.rd] = pc + 32'd4;  // Link
					nextPc = pc + immJ;
					if (immJ == '0) begin
						finalPc   = pc;
						modelDone = 1'b1;
					end
				end
				default: ;
			endcase
			regs[0] = '0;
			pc      = nextPc;
		end
		if (!modelDone) begin
			$display("the reference model never reached the closing self-loop");
			errorCount++;
		end
		expectedStores = expAddr.size();
	endtask

	// Sampled at the falling edge, away from the stimulus edge
	task automatic watchCycle();
		if (!rst_n) begin
			checkValue("dataRead", {31'd0, dataRead}, 32'd0);
			checkValue("dataWrite", {31'd0, dataWrite}, 32'd0);
			checkValue("instAddr", instAddr, `RESET_PC);
			inReset = 1'b1;
		end else if (inReset) begin
			checkValue("instAddr", instAddr, `RESET_PC);  // First cycle out of reset
			checkValue("dataRead", {31'd0, dataRead}, 32'd0);
			checkValue("dataWrite", {31'd0, dataWrite}, 32'd0);
			inReset = 1'b0;
		end else begin
			if (dataRead && !memStall) begin
				if (loadCount < expLoadAddr.size()) begin
					checkValue("dataAddr", dataAddr, expLoadAddr[loadCount]);
				end else begin
					$display("error at %0t: extra load from %h beyond the model's loads",
						$time, dataAddr);
					errorCount++;
				end
				loadCount++;
			end
			if (dataWrite && !memStall) begin
				if (storeCount < expectedStores) begin
					checkValue("dataAddr", dataAddr, expAddr[storeCount]);
					checkValue("dataWdata", dataWdata, expData[storeCount]);
				end else begin
					$display("error at %0t: extra store to %h beyond the model's stores",
						$time, dataAddr);
					errorCount++;
				end
				storeCount++;
			end
			if (instAddr == finalPc)
				reachedEnd = 1'b1;
			if (reachedEnd && !memStall)
				drainCount++;  // Let older instructions leave the pipeline
			if (drainCount == 12) begin
				if (storeCount != expectedStores) begin
					$display("the core committed %0d stores, the model expects %0d",
						storeCount, expectedStores);
					errorCount++;
				end
				if (loadCount != expLoadAddr.size()) begin
					$display("the core performed %0d loads, the model expects %0d",
						loadCount, expLoadAddr.size());
					errorCount++;
				end
				endReached = 1'b1;
			end
		end
	endtask

	initial begin
		endReached     = 1'b0;
		errorCount     = 0;
		storeCount     = 0;
		expectedStores = 0;
		loadCount      = 0;
		inReset        = 1'b0;
		reachedEnd     = 1'b0;
		drainCount     = 0;
		finalPc        = '1;
		for (n = 0; n < 10 && !progReady; n++)
			@(posedge clk);
		if (!progReady) begin
			$display("the program image was never loaded");
			errorCount++;
		end
		runModel();
		for (n = 0; n < 6000 && !endReached; n++) begin
			@(negedge clk);
			watchCycle();
		end
	end

endmodule

// File: verilog/riscvCore.sv
// Five-stage RV32I pipeline top level with stage and bus instances
`timescale 1ns/1ns
`include "core_settings.svh"

module riscvCore (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               memStall,
	output logic [`XLEN-1:0]   instAddr,
	input  logic [`XLEN-1:0]   instData,
	output logic               dataRead,
	output logic               dataWrite,
	output logic [`XLEN-1:0]   dataAddr,
	output logic [`XLEN-1:0]   dataWdata,
	input  logic [`XLEN-1:0]   dataRdata
);
	// Fetch and decode links
	logic               stallHazard;
	logic               redirect;
	logic [`XLEN-1:0]   redirectPc;
	logic [`XLEN-1:0]   idPc;
	core_pkg::instrWord idInstr;

	// Register file read ports
	logic [`REG_AW-1:0] rs1Addr;
	logic [`REG_AW-1:0] rs2Addr;
	logic [`XLEN-1:0]   rs1Data;
	logic [`XLEN-1:0]   rs2Data;

	// ID/EX register outputs
	logic [`REG_AW-1:0] exRs1Addr;
	logic [`REG_AW-1:0] exRs2Addr;
	logic [`XLEN-1:0]   exRs1Data;
	logic [`XLEN-1:0]   exRs2Data;
	logic [`XLEN-1:0]   exImm;
	logic [3:0]         exAluOp;
	logic               exAluSrc;
	logic [`REG_AW-1:0] exRd;
	logic               exRegWrite;
	logic               exMemRead;
	logic               exMemWrite;
	logic               exIsJump;
	logic [`XLEN-1:0]   exPcPlus4;

	fwdBus fwd ();
	wbBus  wb ();

	fetchUnit      uFetch (.*);
	decodeStage    uDecode (.*);
	registerFile   uRegFile (.*);
	hazardUnit     uHazard (.*);
	executeStage   uExecute (.*);
	writebackStage uWriteback (.*);

endmodule

// File: verilog/writebackStage.sv
// MEM/WB register and write-back value select
`timescale 1ns/1ns
`include "core_settings.svh"

module writebackStage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             memStall,
	fwdBus.sink              fwd,
	input  logic [`XLEN-1:0] dataRdata,
	wbBus.source             wb
);
	logic [`XLEN-1:0]   resultReg;
	logic [`XLEN-1:0]   loadData;
	logic [`REG_AW-1:0] rdReg;
	logic               writeReg;
	logic               isLoad;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdReg    <= '0;
			writeReg <= 1'b0;
			isLoad   <= 1'b0;
		end else if (!memStall) begin
			rdReg    <= fwd.memRd;
			writeReg <= fwd.memRegWrite;
			isLoad   <= fwd.memIsLoad;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			resultReg <= fwd.memResult;
			loadData  <= dataRdata;  // Same-cycle memory answer
		end
	end

	assign wb.wbData  = isLoad ? loadData : resultReg;
	assign wb.wbRd    = rdReg;
	assign wb.wbWrite = writeReg;

endmodule

// File: verilog/executeStage.sv
// Operand forwarding, ALU, result select and the EX/MEM register
`timescale 1ns/1ns
`include "core_settings.svh"

module executeStage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               memStall,
	input  logic [`REG_AW-1:0] exRs1Addr,
	input  logic [`REG_AW-1:0] exRs2Addr,
	input  logic [`XLEN-1:0]   exRs1Data,
	input  logic [`XLEN-1:0]   exRs2Data,
	input  logic [`XLEN-1:0]   exImm,
	input  logic [3:0]         exAluOp,
	input  logic               exAluSrc,
	input  logic [`REG_AW-1:0] exRd,
	input  logic               exRegWrite,
	input  logic               exMemRead,
	input  logic               exMemWrite,
	input  logic               exIsJump,
	input  logic [`XLEN-1:0]   exPcPlus4,
	wbBus.sink                 wb,
	fwdBus.source              fwd,
	output logic               dataRead,
	output logic               dataWrite,
	output logic [`XLEN-1:0]   dataAddr,
	output logic [`XLEN-1:0]   dataWdata
);
	logic [`XLEN-1:0]   opA;
	logic [`XLEN-1:0]   storeData;
	logic [`XLEN-1:0]   opB;
	logic [`XLEN-1:0]   aluValue;
	logic [`XLEN-1:0]   memResult;
	logic [`XLEN-1:0]   memStoreData;
	logic [`REG_AW-1:0] memRd;
	logic               memRegWrite;
	logic               memIsLoad;
	logic               memWriteEn;

	function automatic logic [`XLEN-1:0] fwdValue(input logic [`REG_AW-1:0] addr,
			input logic [`XLEN-1:0] regData);
		if (addr != '0 && memRegWrite && memRd == addr)
			return memResult;
		else if (addr != '0 && wb.wbWrite && wb.wbRd == addr)
			return wb.wbData;
		else
			return regData;
	endfunction

	assign opA       = fwdValue(exRs1Addr, exRs1Data);
	assign storeData = fwdValue(exRs2Addr, exRs2Data);
	assign opB       = exAluSrc ? exImm : storeData;

	always_comb begin
		case (exAluOp)
			`ALU_SUB: aluValue = opA - opB;
			`ALU_SLL: aluValue = opA << opB[4:0];
			`ALU_SLT: aluValue = {31'd0, $signed(opA) < $signed(opB)};
			`ALU_XOR: aluValue = opA ^ opB;
			`ALU_SRL: aluValue = opA >> opB[4:0];
			`ALU_SRA: aluValue = $signed(opA) >>> opB[4:0];
			`ALU_OR:  aluValue = opA | opB;
			`ALU_AND: aluValue = opA & opB;
			default:  aluValue = opA + opB;  // add, address calc
		endcase
	end

	// ====================================================================
	// EX/MEM register
	// ====================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memRd       <= '0;
			memRegWrite <= 1'b0;
			memIsLoad   <= 1'b0;
			memWriteEn  <= 1'b0;
		end else if (!memStall) begin
			memRd       <= exRd;
			memRegWrite <= exRegWrite;
			memIsLoad   <= exMemRead;
			memWriteEn  <= exMemWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			memResult    <= exIsJump ? exPcPlus4 : aluValue;
			memStoreData <= storeData;
		end
	end

	assign fwd.memResult   = memResult;
	assign fwd.memRd       = memRd;
	assign fwd.memRegWrite = memRegWrite;
	assign fwd.memIsLoad   = memIsLoad;

	// Data memory port
	assign dataRead  = memIsLoad;
	assign dataWrite = memWriteEn;
	assign dataAddr  = memResult;
	assign dataWdata = memStoreData;

endmodule

// File: verilog/hazardUnit.sv
// Load-use and branch-dependency stall detection
`timescale 1ns/1ns
`include "core_settings.svh"

module hazardUnit (
	input  core_pkg::instrWord idInstr,
	input  logic [`REG_AW-1:0] exRd,
	input  logic               exRegWrite,
	input  logic               exMemRead,
	fwdBus.sink                fwd,
	output logic               stallHazard
);
	logic [`REG_AW-1:0] rs1;
	logic [`REG_AW-1:0] rs2;
	logic               isBranch;
	logic               exHit;
	logic               memHit;
	logic               loadUse;
	logic               branchDep;

	assign rs1      = idInstr.rType.rs1;
	assign rs2      = idInstr.rType.rs2;
	assign isBranch = idInstr.rType.opcode == `OP_BRANCH;

	// Source match against EX and MEM destinations
	assign exHit  = exRd != '0 && (exRd == rs1 || exRd == rs2);
	assign memHit = fwd.memRd != '0 && (fwd.memRd == rs1 || fwd.memRd == rs2);

	assign loadUse   = exMemRead && exHit;
	assign branchDep = isBranch && ((exRegWrite && exHit) || (fwd.memIsLoad && memHit));

	assign stallHazard = loadUse || branchDep;

endmodule

// File: verilog/registerFile.sv
// 32 x 32 register file with x0 tied to zero and write-through bypass
`timescale 1ns/1ns
`include "core_settings.svh"

module registerFile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`REG_AW-1:0] rs1Addr,
	input  logic [`REG_AW-1:0] rs2Addr,
	output logic [`XLEN-1:0]   rs1Data,
	output logic [`XLEN-1:0]   rs2Data,
	wbBus.sink                 wb
);
	logic [`XLEN-1:0] regs [1 << `REG_AW];

	// Same-cycle write shows up on the read port
	function automatic logic [`XLEN-1:0] readPort(input logic [`REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb.wbWrite && wb.wbRd == addr)
			return wb.wbData;
		else
			return regs[addr];
	endfunction

	assign rs1Data = readPort(rs1Addr);
	assign rs2Data = readPort(rs2Addr);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << `REG_AW); i++)
				regs[i] <= '0;
		end else if (wb.wbWrite && wb.wbRd != '0) begin
			regs[wb.wbRd] <= wb.wbData;
		end
	end

endmodule

// File: verilog/decodeStage.sv
// Main control, immediate generation, branch compare and the ID/EX register
`timescale 1ns/1ns
`include "core_settings.svh"

module decodeStage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               memStall,
	input  logic               stallHazard,
	input  logic [`XLEN-1:0]   idPc,
	input  core_pkg::instrWord idInstr,
	output logic [`REG_AW-1:0] rs1Addr,
	output logic [`REG_AW-1:0] rs2Addr,
	input  logic [`XLEN-1:0]   rs1Data,
	input  logic [`XLEN-1:0]   rs2Data,
	fwdBus.sink                fwd,
	wbBus.sink                 wb,
	output logic               redirect,
	output logic [`XLEN-1:0]   redirectPc,
	output logic [`REG_AW-1:0] exRs1Addr,
	output logic [`REG_AW-1:0] exRs2Addr,
	output logic [`XLEN-1:0]   exRs1Data,
	output logic [`XLEN-1:0]   exRs2Data,
	output logic [`XLEN-1:0]   exImm,
	output logic [3:0]         exAluOp,
	output logic               exAluSrc,
	output logic [`REG_AW-1:0] exRd,
	output logic               exRegWrite,
	output logic               exMemRead,
	output logic               exMemWrite,
	output logic               exIsJump,
	output logic [`XLEN-1:0]   exPcPlus4
);
	logic [2:0]       funct3;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immJ;
	logic [`XLEN-1:0] imm;
	logic [3:0]       aluOp;
	logic             aluSrc;
	logic             regWrite;
	logic             memRead;
	logic             memWrite;
	logic             isBranch;
	logic             isJump;
	logic [`XLEN-1:0] cmpA;
	logic [`XLEN-1:0] cmpB;
	logic             taken;

	// MEM result first, then WB, then the file
	function automatic logic [`XLEN-1:0] fwdValue(input logic [`REG_AW-1:0] addr,
			input logic [`XLEN-1:0] fileData);
		if (addr != '0 && fwd.memRegWrite && fwd.memRd == addr)
			return fwd.memResult;
		else if (addr != '0 && wb.wbWrite && wb.wbRd == addr)
			return wb.wbData;
		else
			return fileData;
	endfunction

	assign rs1Addr = idInstr.rType.rs1;
	assign rs2Addr = idInstr.rType.rs2;
	assign funct3  = idInstr.rType.funct3;

	// ====================================================================
	// Immediates and main control
	// ====================================================================
	assign immI = {{20{idInstr.iType.imm[11]}}, idInstr.iType.imm};
	assign immS = {{20{idInstr.sType.immHi[6]}}, idInstr.sType.immHi, idInstr.sType.immLo};
	assign immB = {{19{idInstr.bType.immSign}}, idInstr.bType.immSign,
		idInstr.bType.immBit11, idInstr.bType.immHi, idInstr.bType.immLo, 1'b0};
	assign immJ = {{11{idInstr.jType.immSign}}, idInstr.jType.immSign,
		idInstr.jType.immHi, idInstr.jType.immBit11, idInstr.jType.immLo, 1'b0};

	always_comb begin
		regWrite = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		aluSrc   = 1'b0;
		isBranch = 1'b0;
		isJump   = 1'b0;
		aluOp    = `ALU_ADD;
		imm      = '0;
		case (idInstr.rType.opcode)
			`OP_RTYPE: begin
				regWrite = 1'b1;
				aluOp    = {idInstr.rType.funct7[5], funct3};
			end
			`OP_ITYPE: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				aluOp    = {(funct3 == 3'b101) & idInstr.rType.funct7[5], funct3};  // srai only
				imm      = immI;
			end
			`OP_LOAD: begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				aluSrc   = 1'b1;
				imm      = immI;
			end
			`OP_STORE: begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
				imm      = immS;
			end
			`OP_BRANCH: begin
				isBranch = 1'b1;
				imm      = immB;
			end
			`OP_JAL: begin
				regWrite = 1'b1;
				isJump   = 1'b1;
				imm      = immJ;
			end
			default: ;
		endcase
	end

	// Branch resolution in ID
	assign cmpA       = fwdValue(rs1Addr, rs1Data);
	assign cmpB       = fwdValue(rs2Addr, rs2Data);
	assign taken      = isBranch && (funct3[0] ? (cmpA != cmpB) : (cmpA == cmpB));
	assign redirect   = (taken || isJump) && !stallHazard;  // Wait for operands
	assign redirectPc = idPc + imm;

	// ====================================================================
	// ID/EX register
	// ====================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exRd       <= '0;
			exRegWrite <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exIsJump   <= 1'b0;
		end else if (!memStall) begin
			exRd       <= stallHazard ? '0 : idInstr.rType.rd;
			exRegWrite <= regWrite && !stallHazard;
			exMemRead  <= memRead && !stallHazard;
			exMemWrite <= memWrite && !stallHazard;
			exIsJump   <= isJump && !stallHazard;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			exRs1Addr <= rs1Addr;
			exRs2Addr <= rs2Addr;
			exRs1Data <= rs1Data;
			exRs2Data <= rs2Data;
			exImm     <= imm;
			exAluOp   <= aluOp;
			exAluSrc  <= aluSrc;
			exPcPlus4 <= idPc + 32'd4;  // jal link value
		end
	end

endmodule

// File: verilog/fetchUnit.sv
// PC register, next-PC selection and the IF/ID register
`timescale 1ns/1ns
`include "core_settings.svh"

module fetchUnit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               memStall,
	input  logic               stallHazard,
	input  logic               redirect,
	input  logic [`XLEN-1:0]   redirectPc,
	input  logic [`XLEN-1:0]   instData,
	output logic [`XLEN-1:0]   instAddr,
	output logic [`XLEN-1:0]   idPc,
	output core_pkg::instrWord idInstr
);
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pcNext;

	assign instAddr = pc;

	// Not-taken prediction, decode corrects it
	always_comb begin
		if (memStall)
			pcNext = pc;
		else if (redirect)
			pcNext = redirectPc;
		else if (stallHazard)
			pcNext = pc;      // Bubble going into EX
		else
			pcNext = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RESET_PC;
		else
			pc <= pcNext;
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idPc    <= `RESET_PC;
			idInstr <= `NOP_INSTR;
		end else if (!memStall && !stallHazard) begin
			idPc    <= pc;
			idInstr <= redirect ? `NOP_INSTR : instData;  // Squash wrong-path word
		end
	end

endmodule

// File: verilog/pipeBus.sv
// Forwarding bus from EX/MEM and write-back bus from MEM/WB
`timescale 1ns/1ns
`include "core_settings.svh"

// ====================================================================
// EX/MEM state seen by decode, hazard detection and execute
// ====================================================================
interface fwdBus;
	logic [`XLEN-1:0]   memResult;   // ALU value or jal link
	logic [`REG_AW-1:0] memRd;
	logic               memRegWrite;
	logic               memIsLoad;

	modport source (output memResult, output memRd, output memRegWrite,
		output memIsLoad);
	modport sink (input memResult, input memRd, input memRegWrite,
		input memIsLoad);
endinterface

// ====================================================================
// Write-back port into the register file and the forwarding muxes
// ====================================================================
interface wbBus;
	logic [`XLEN-1:0]   wbData;
	logic [`REG_AW-1:0] wbRd;
	logic               wbWrite;

	modport source (output wbData, output wbRd, output wbWrite);
	modport sink (input wbData, input wbRd, input wbWrite);
endinterface

// File: verilog/core_pkg.sv
// Instruction word union with R, I, S, B and J format views
package core_pkg;

	// Same 32 bits seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;   // imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;   // imm[4:0]
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic       immSign; // imm[12]
			logic [5:0] immHi;   // imm[10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] immLo;   // imm[4:1]
			logic       immBit11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic       immSign; // imm[20]
			logic [9:0] immLo;   // imm[10:1]
			logic       immBit11;
			logic [7:0] immHi;   // imm[19:12]
			logic [4:0] rd;
			logic [6:0] opcode;
		} jType;
	} instrWord;

endpackage

// File: include/core_settings.svh
// Core widths, opcodes, ALU operation codes, reset PC and NOP word
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN      32
`define REG_AW    5
`define RESET_PC  32'h0000_0000
`define NOP_INSTR 32'h0000_0013  // addi x0, x0, 0

// Major opcodes
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

// ALU codes built as {funct7[5], funct3}
`define ALU_ADD   4'b0000
`define ALU_SUB   4'b1000
`define ALU_SLL   4'b0001
`define ALU_SLT   4'b0010
`define ALU_XOR   4'b0100
`define ALU_SRL   4'b0101
`define ALU_SRA   4'b1101
`define ALU_OR    4'b0110
`define ALU_AND   4'b0111

`endif
